// File: Makefile
VERILATOR ?= verilator
TOP       ?= openmips_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	elif ! grep -q "Verification passed" $(LOG); then \
		echo "FAIL: run ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/cpu_pkg.sv
package cpu_pkg;

    // ============================================================
    // Datapath widths
    // ============================================================

    typedef logic [31:0] word_t;         // Register and ALU data
    typedef logic [31:0] inst_addr_t;    // Byte address of an instruction
    typedef logic [4:0]  reg_addr_t;     // GPR index

    localparam reg_addr_t NOP_REG = 5'd0;    // r0, reads as zero

    // ============================================================
    // Instruction encodings
    // ============================================================

    // Primary opcode, inst[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // SPECIAL function field, inst[5:0]
    localparam logic [5:0] FN_AND = 6'b100100;
    localparam logic [5:0] FN_OR  = 6'b100101;
    localparam logic [5:0] FN_XOR = 6'b100110;
    localparam logic [5:0] FN_NOR = 6'b100111;

    // ============================================================
    // Decode to execute encodings
    // ============================================================

    typedef enum logic [7:0] {
        ALU_NOP = 8'b0000_0000,
        ALU_AND = 8'b0010_0100,
        ALU_OR  = 8'b0010_0101,
        ALU_XOR = 8'b0010_0110,
        ALU_NOR = 8'b0010_0111
    } aluop_t;

    typedef enum logic [2:0] {
        RES_NOP   = 3'b000,
        RES_LOGIC = 3'b001
    } alusel_t;

endpackage

// File: decode/id.sv
module id (
    input  cpu_pkg::inst_addr_t pc_i,
    input  cpu_pkg::word_t      inst_i,
    input  cpu_pkg::word_t      reg1_data_i,
    input  cpu_pkg::word_t      reg2_data_i,
    // Register file read side
    output logic                reg1_read_o,
    output logic                reg2_read_o,
    output cpu_pkg::reg_addr_t  reg1_addr_o,
    output cpu_pkg::reg_addr_t  reg2_addr_o,
    // To execute
    output cpu_pkg::aluop_t     aluop_o,
    output cpu_pkg::alusel_t    alusel_o,
    output cpu_pkg::word_t      reg1_o,
    output cpu_pkg::word_t      reg2_o,
    output cpu_pkg::reg_addr_t  wd_o,
    output logic                wreg_o,
    // Forwarding from execute
    input  logic                ex_wreg_i,
    input  cpu_pkg::reg_addr_t  ex_wd_i,
    input  cpu_pkg::word_t      ex_wdata_i,
    // Forwarding from memory
    input  logic                mem_wreg_i,
    input  cpu_pkg::reg_addr_t  mem_wd_i,
    input  cpu_pkg::word_t      mem_wdata_i
);

    import cpu_pkg::*;

    logic [5:0] op;
    logic [4:0] shamt;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic       valid;
    word_t      imm;

    assign op         = inst_i[31:26];
    assign rs         = inst_i[25:21];
    assign rt         = inst_i[20:16];
    assign rd         = inst_i[15:11];
    assign shamt      = inst_i[10:6];
    assign funct      = inst_i[5:0];

    // ============================================================
    // Instruction decode
    // ============================================================

    always_comb begin
        valid       = 1'b0;
        aluop_o     = ALU_NOP;
        reg1_read_o = 1'b0;
        reg2_read_o = 1'b0;
        reg1_addr_o = rs;
        reg2_addr_o = rt;
        wd_o        = rd;
        imm         = '0;

        case (op)
            OP_SPECIAL: begin
                reg1_read_o = 1'b1;
                reg2_read_o = 1'b1;
                valid       = (shamt == 5'd0);
                case (funct)
                    FN_AND:  aluop_o = ALU_AND;
                    FN_OR:   aluop_o = ALU_OR;
                    FN_XOR:  aluop_o = ALU_XOR;
                    FN_NOR:  aluop_o = ALU_NOR;
                    default: valid = 1'b0;
                endcase
            end
            OP_ORI, OP_ANDI, OP_XORI, OP_LUI: begin
                valid       = 1'b1;
                reg1_read_o = 1'b1;
                wd_o        = rt;
                imm         = {16'h0000, inst_i[15:0]};    // Zero-extended
                case (op)
                    OP_ANDI: aluop_o = ALU_AND;
                    OP_XORI: aluop_o = ALU_XOR;
                    default: aluop_o = ALU_OR;
                endcase
                if (op == OP_LUI) begin
                    imm = {inst_i[15:0], 16'h0000};
                end
            end
            default: ;
        endcase

        // Anything not recognised leaves as a bubble
        if (!valid) begin
            aluop_o     = ALU_NOP;
            reg1_read_o = 1'b0;
            reg2_read_o = 1'b0;
            wd_o        = NOP_REG;
            imm         = '0;
        end
        wreg_o   = valid;
        alusel_o = wreg_o ? RES_LOGIC : RES_NOP;
    end

    // ============================================================
    // Operand select and forwarding
    // ============================================================

    function automatic word_t operand(input logic rd_en, input reg_addr_t addr,
                                      input word_t rf_data);
        word_t res;
        if (!rd_en) begin
            res = imm;
        end else if (ex_wreg_i && ex_wd_i == addr && addr != NOP_REG) begin
            res = ex_wdata_i;                   // Newest result first
        end else if (mem_wreg_i && mem_wd_i == addr && addr != NOP_REG) begin
            res = mem_wdata_i;
        end else begin
            res = rf_data;                      // Includes writeback write-through
        end
        return res;
    endfunction

    always_comb begin
        reg1_o = operand(reg1_read_o, reg1_addr_o, reg1_data_i);
        reg2_o = operand(reg2_read_o, reg2_addr_o, reg2_data_i);
    end

endmodule

// File: logic/ex.sv
module ex (
    input  logic               clk,
    input  logic               reset_i,
    input  cpu_pkg::aluop_t    aluop_i,
    input  cpu_pkg::alusel_t   alusel_i,
    input  cpu_pkg::word_t     reg1_i,
    input  cpu_pkg::word_t     reg2_i,
    input  cpu_pkg::reg_addr_t wd_i,
    input  logic               wreg_i,
    output logic               wreg_o,
    output cpu_pkg::reg_addr_t wd_o,
    output cpu_pkg::word_t     wdata_o
);

    import cpu_pkg::*;

    aluop_t  aluop_q;
    alusel_t alusel_q;
    word_t   reg1_q;
    word_t   reg2_q;
    word_t   logic_res;

    // ============================================================
    // ID/EX register
    // ============================================================

    always_ff @(posedge clk) begin
        if (reset_i) begin
            aluop_q  <= ALU_NOP;
            alusel_q <= RES_NOP;
            wd_o     <= NOP_REG;
            wreg_o   <= 1'b0;
        end else begin
            aluop_q  <= aluop_i;
            alusel_q <= alusel_i;
            wd_o     <= wd_i;
            wreg_o   <= wreg_i;
        end
    end

    always_ff @(posedge clk) begin
        reg1_q <= reg1_i;
        reg2_q <= reg2_i;
    end

    // ============================================================
    // Logic ALU
    // ============================================================

    always_comb begin
        case (aluop_q)
            ALU_AND: logic_res = reg1_q & reg2_q;
            ALU_OR:  logic_res = reg1_q | reg2_q;
            ALU_XOR: logic_res = reg1_q ^ reg2_q;
            ALU_NOR: logic_res = ~(reg1_q | reg2_q);
            default: logic_res = '0;
        endcase
    end

    assign wdata_o = (alusel_q == RES_LOGIC) ? logic_res : '0;   // Bubble gives zero

endmodule

// File: logic/fetch.sv
module fetch #(
    parameter cpu_pkg::inst_addr_t RESET_PC = '0
) (
    input  logic                clk,
    input  logic                reset_i,
    output cpu_pkg::inst_addr_t pc_o,
    output logic                rom_ce_o,
    input  cpu_pkg::word_t      inst_i,
    output cpu_pkg::inst_addr_t if_pc_o,
    output cpu_pkg::word_t      if_inst_o
);

    import cpu_pkg::*;

    // Program counter, held for the cycle where the ROM comes out of reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rom_ce_o <= 1'b0;
            pc_o     <= RESET_PC;
        end else begin
            rom_ce_o <= 1'b1;
            if (rom_ce_o) begin
                pc_o <= pc_o + 32'd4;
            end
        end
    end

    // IF/ID register
    always_ff @(posedge clk) begin
        if_pc_o <= pc_o;
        if (reset_i || !rom_ce_o) begin
            if_inst_o <= '0;                // All-zero word is sll r0, r0, 0
        end else begin
            if_inst_o <= inst_i;
        end
    end

endmodule

// File: logic/mem_wb.sv
module mem_wb (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               ex_wreg_i,
    input  cpu_pkg::reg_addr_t ex_wd_i,
    input  cpu_pkg::word_t     ex_wdata_i,
    output logic               mem_wreg_o,
    output cpu_pkg::reg_addr_t mem_wd_o,
    output cpu_pkg::word_t     mem_wdata_o,
    output logic               wb_we_o,
    output cpu_pkg::reg_addr_t wb_addr_o,
    output cpu_pkg::word_t     wb_data_o
);

    import cpu_pkg::*;

    // EX/MEM register, also the second forwarding source
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_wreg_o <= 1'b0;
            mem_wd_o   <= NOP_REG;
        end else begin
            mem_wreg_o <= ex_wreg_i;
            mem_wd_o   <= ex_wd_i;
        end
        mem_wdata_o <= ex_wdata_i;
    end

    // MEM/WB register, memory stage passes through untouched
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_we_o   <= 1'b0;
            wb_addr_o <= NOP_REG;
        end else begin
            wb_we_o   <= mem_wreg_o;
            wb_addr_o <= mem_wd_o;
        end
        wb_data_o <= mem_wdata_o;
    end

endmodule

// File: logic/openmips.sv
module openmips #(
    parameter cpu_pkg::inst_addr_t RESET_PC = '0
) (
    input  logic                clk,
    input  logic                reset_i,
    // Instruction ROM
    output cpu_pkg::inst_addr_t rom_addr_o,
    output logic                rom_ce_o,
    input  cpu_pkg::word_t      rom_data_i,
    // Writeback port
    output logic                wb_we_o,
    output cpu_pkg::reg_addr_t  wb_addr_o,
    output cpu_pkg::word_t      wb_data_o
);

    import cpu_pkg::*;

    inst_addr_t if_pc;
    word_t      if_inst;

    logic       reg1_read;
    logic       reg2_read;
    reg_addr_t  reg1_addr;
    reg_addr_t  reg2_addr;
    word_t      reg1_data;
    word_t      reg2_data;

    aluop_t     id_aluop;
    alusel_t    id_alusel;
    word_t      id_reg1;
    word_t      id_reg2;
    reg_addr_t  id_wd;
    logic       id_wreg;

    logic       ex_wreg;
    reg_addr_t  ex_wd;
    word_t      ex_wdata;

    logic       mem_wreg;
    reg_addr_t  mem_wd;
    word_t      mem_wdata;

    fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk       (clk),
        .reset_i   (reset_i),
        .pc_o      (rom_addr_o),
        .rom_ce_o  (rom_ce_o),
        .inst_i    (rom_data_i),
        .if_pc_o   (if_pc),
        .if_inst_o (if_inst)
    );

    id u_id (
        .pc_i        (if_pc),
        .inst_i      (if_inst),
        .reg1_data_i (reg1_data),
        .reg2_data_i (reg2_data),
        .reg1_read_o (reg1_read),
        .reg2_read_o (reg2_read),
        .reg1_addr_o (reg1_addr),
        .reg2_addr_o (reg2_addr),
        .aluop_o     (id_aluop),
        .alusel_o    (id_alusel),
        .reg1_o      (id_reg1),
        .reg2_o      (id_reg2),
        .wd_o        (id_wd),
        .wreg_o      (id_wreg),
        .ex_wreg_i   (ex_wreg),
        .ex_wd_i     (ex_wd),
        .ex_wdata_i  (ex_wdata),
        .mem_wreg_i  (mem_wreg),
        .mem_wd_i    (mem_wd),
        .mem_wdata_i (mem_wdata)
    );

    regfile u_regfile (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (wb_we_o),
        .waddr_i  (wb_addr_o),
        .wdata_i  (wb_data_o),
        .re1_i    (reg1_read),
        .raddr1_i (reg1_addr),
        .rdata1_o (reg1_data),
        .re2_i    (reg2_read),
        .raddr2_i (reg2_addr),
        .rdata2_o (reg2_data)
    );

    ex u_ex (
        .clk      (clk),
        .reset_i  (reset_i),
        .aluop_i  (id_aluop),
        .alusel_i (id_alusel),
        .reg1_i   (id_reg1),
        .reg2_i   (id_reg2),
        .wd_i     (id_wd),
        .wreg_i   (id_wreg),
        .wreg_o   (ex_wreg),
        .wd_o     (ex_wd),
        .wdata_o  (ex_wdata)
    );

    mem_wb u_mem_wb (
        .clk         (clk),
        .reset_i     (reset_i),
        .ex_wreg_i   (ex_wreg),
        .ex_wd_i     (ex_wd),
        .ex_wdata_i  (ex_wdata),
        .mem_wreg_o  (mem_wreg),
        .mem_wd_o    (mem_wd),
        .mem_wdata_o (mem_wdata),
        .wb_we_o     (wb_we_o),
        .wb_addr_o   (wb_addr_o),
        .wb_data_o   (wb_data_o)
    );

endmodule

// File: logic/regfile.sv
module regfile (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               we_i,
    input  cpu_pkg::reg_addr_t waddr_i,
    input  cpu_pkg::word_t     wdata_i,
    input  logic               re1_i,
    input  cpu_pkg::reg_addr_t raddr1_i,
    output cpu_pkg::word_t     rdata1_o,
    input  logic               re2_i,
    input  cpu_pkg::reg_addr_t raddr2_i,
    output cpu_pkg::word_t     rdata2_o
);

    import cpu_pkg::*;

    word_t regs [32];
    logic  wr_en;

    assign wr_en = we_i && !reset_i && (waddr_i != NOP_REG);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Read port 1
    always_comb begin
        if (!re1_i || raddr1_i == NOP_REG) begin
            rdata1_o = '0;
        end else if (wr_en && waddr_i == raddr1_i) begin
            rdata1_o = wdata_i;                 // Write-through
        end else begin
            rdata1_o = regs[raddr1_i];
        end
    end

    // Read port 2
    always_comb begin
        if (!re2_i || raddr2_i == NOP_REG) begin
            rdata2_o = '0;
        end else if (wr_en && waddr_i == raddr2_i) begin
            rdata2_o = wdata_i;
        end else begin
            rdata2_o = regs[raddr2_i];
        end
    end

endmodule

// File: tb/openmips_assert.sv
module openmips_assert (
    input logic                clk,
    input logic                reset_i,
    input cpu_pkg::inst_addr_t rom_addr_o,
    input logic                rom_ce_o,
    input logic                wb_we_o,
    input cpu_pkg::reg_addr_t  wb_addr_o,
    input logic                reg1_read,
    input cpu_pkg::reg_addr_t  reg1_addr,
    input cpu_pkg::word_t      reg1_data,
    input logic                reg2_read,
    input cpu_pkg::reg_addr_t  reg2_addr,
    input cpu_pkg::word_t      reg2_data
);

    timeunit 1ns;
    timeprecision 100ps;

    import cpu_pkg::*;

    wb_quiet_after_reset: assert property (@(posedge clk)
        ($past(reset_i) && !reset_i) |-> !wb_we_o)
        else $error("writeback enable high in the first cycle after reset");

    pc_step: assert property (@(posedge clk) disable iff (reset_i)
        (rom_ce_o && $past(rom_ce_o)) |-> rom_addr_o == $past(rom_addr_o) + 32'd4)
        else $error("fetch address did not advance by 4");

    // Write-through must never leak a write to r0
    r0_read_port1: assert property (@(posedge clk) disable iff (reset_i)
        (wb_we_o && wb_addr_o == NOP_REG && reg1_read && reg1_addr == NOP_REG)
        |-> reg1_data == '0)
        else $error("r0 read on port 1 changed by a write to r0");

    r0_read_port2: assert property (@(posedge clk) disable iff (reset_i)
        (wb_we_o && wb_addr_o == NOP_REG && reg2_read && reg2_addr == NOP_REG)
        |-> reg2_data == '0)
        else $error("r0 read on port 2 changed by a write to r0");

endmodule

bind openmips openmips_assert u_openmips_assert (
    .clk        (clk),
    .reset_i    (reset_i),
    .rom_addr_o (rom_addr_o),
    .rom_ce_o   (rom_ce_o),
    .wb_we_o    (wb_we_o),
    .wb_addr_o  (wb_addr_o),
    .reg1_read  (reg1_read),
    .reg1_addr  (reg1_addr),
    .reg1_data  (reg1_data),
    .reg2_read  (reg2_read),
    .reg2_addr  (reg2_addr),
    .reg2_data  (reg2_data)
);

// File: tb/openmips_tb.sv
module openmips_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // MIPS32 encodings of the logic subset
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ANDI    = 6'h0C;
    localparam logic [5:0] OP_ORI     = 6'h0D;
    localparam logic [5:0] OP_XORI    = 6'h0E;
    localparam logic [5:0] OP_LUI     = 6'h0F;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_XOR     = 6'h26;
    localparam logic [5:0] FN_NOR     = 6'h27;

    localparam logic [31:0] RESET_PC  = 32'h0000_0040;
    localparam int          ROM_WORDS = 64;
    localparam logic [31:0] ROM_BYTES = 32'd256;
    localparam int          MAX_CYCLES = 400;   // Six tests of 20 to 30 cycles, plenty of slack

    logic        clk;
    logic        reset_i;
    logic [31:0] rom_addr;
    logic        rom_ce;
    logic [31:0] rom_data;
    logic        wb_we;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] rom_off;
    logic [31:0] prog [$];
    logic [31:0] shadow [32];           // Architectural state of the reference model
    logic [4:0]  exp_addr [$];
    logic [31:0] exp_data [$];
    logic [4:0]  pop_addr;
    logic [31:0] pop_data;

    int cycle_count  = 0;
    int error_count  = 0;
    int check_count  = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    openmips #(
        .RESET_PC (RESET_PC)
    ) UUT (
        .clk        (clk),
        .reset_i    (reset_i),
        .rom_addr_o (rom_addr),
        .rom_ce_o   (rom_ce),
        .rom_data_i (rom_data),
        .wb_we_o    (wb_we),
        .wb_addr_o  (wb_addr),
        .wb_data_o  (wb_data)
    );

    always #4 clk = ~clk;

    // Instruction ROM, answers in the same cycle
    assign rom_off  = rom_addr - RESET_PC;
    assign rom_data = (rom_ce && rom_off < ROM_BYTES) ? rom[rom_off[7:2]] : '0;

    // ============================================================
    // Writeback monitor and timeout
    // ============================================================

    always @(posedge clk) begin
        if (wb_we === 1'b1) begin
            if (exp_addr.size() == 0) begin
                $display("Unexpected write at %0t: r%0d = %h with no write pending",
                         $time, wb_addr, wb_data);
                error_count++;
            end else begin
                pop_addr = exp_addr.pop_front();
                pop_data = exp_data.pop_front();
                check_count++;
                if (wb_addr !== pop_addr || wb_data !== pop_data) begin
                    $display("CHECK FAILED at %0t: wrote r%0d = %h, expected r%0d = %h",
                             $time, wb_addr, wb_data, pop_addr, pop_data);
                    error_count++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // ============================================================
    // Encoding and reference model
    // ============================================================

    function automatic logic [31:0] r_inst(input logic [5:0] fn, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_inst(input logic [5:0] op, input logic [4:0] rt,
                                           input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic model_inst(input logic [31:0] inst);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] zimm;
        logic [31:0] res;
        logic [4:0]  dest;
        logic        valid;
        a     = shadow[inst[25:21]];
        b     = shadow[inst[20:16]];
        zimm  = {16'h0000, inst[15:0]};
        res   = '0;
        dest  = inst[20:16];
        valid = 1'b1;
        case (inst[31:26])
            OP_SPECIAL: begin
                dest = inst[15:11];
                if (inst[10:6] != 5'd0) begin
                    valid = 1'b0;
                end else begin
                    case (inst[5:0])
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_NOR:  res = ~(a | b);
                        default: valid = 1'b0;
                    endcase
                end
            end
            OP_ANDI: res = a & zimm;
            OP_ORI:  res = a | zimm;
            OP_XORI: res = a ^ zimm;
            OP_LUI:  res = {inst[15:0], 16'h0000} | a;
            default: valid = 1'b0;
        endcase
        if (valid) begin
            exp_addr.push_back(dest);
            exp_data.push_back(res);
            if (dest != 5'd0) begin
                shadow[dest] = res;
            end
        end
    endtask

    // Reset, load and run one program, then report the test
    task automatic run_program(input string name);
        int errors_before;
        int budget;
        int waited;
        errors_before = error_count;
        budget = prog.size() + 12;
        waited = 0;
        @(posedge clk);
        reset_i <= 1'b1;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = '0;
        end
        foreach (prog[i]) begin
            rom[i] = prog[i];
            model_inst(prog[i]);
        end
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        while (exp_addr.size() != 0 && waited < budget) begin
            @(negedge clk);
            waited++;
        end
        repeat (6) @(posedge clk);     // Catch stray writes from trailing bubbles
        if (exp_addr.size() != 0) begin
            $display("Test %s: %0d expected writes never reached writeback",
                     name, exp_addr.size());
            error_count += exp_addr.size();
            exp_addr.delete();
            exp_data.delete();
        end
        tests_run++;
        if (error_count == errors_before) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: FAILED with %0d errors", name, error_count - errors_before);
        end
    endtask

    // ============================================================
    // Directed tests
    // ============================================================

    task automatic ori_fill();
        prog.delete();
        for (int r = 1; r <= 8; r++) begin
            prog.push_back(i_inst(OP_ORI, 5'(r), 5'd0, 16'($urandom())));
        end
        run_program("ori_fill");
    endtask

    task automatic lui_ori_constants();
        prog.delete();
        for (int r = 9; r <= 12; r++) begin
            prog.push_back(i_inst(OP_LUI, 5'(r), 5'd0, 16'($urandom())));
            prog.push_back(i_inst(OP_ORI, 5'(r), 5'(r), 16'($urandom())));
        end
        run_program("lui_ori_constants");
    endtask

    task automatic dependent_chain();
        prog.delete();
        prog.push_back(i_inst(OP_LUI, 5'd13, 5'd0, 16'hA5A5));
        prog.push_back(i_inst(OP_ORI, 5'd13, 5'd13, 16'h0F0F));
        prog.push_back(i_inst(OP_LUI, 5'd14, 5'd0, 16'h3C3C));
        prog.push_back(i_inst(OP_ORI, 5'd14, 5'd14, 16'hF00F));
        prog.push_back(r_inst(FN_AND, 5'd15, 5'd13, 5'd14));   // r14 from execute
        prog.push_back(r_inst(FN_OR, 5'd16, 5'd15, 5'd13));    // r13 from the register file
        prog.push_back(r_inst(FN_XOR, 5'd17, 5'd16, 5'd14));   // r14 through write-through
        prog.push_back(r_inst(FN_NOR, 5'd18, 5'd15, 5'd17));
        prog.push_back(r_inst(FN_XOR, 5'd19, 5'd17, 5'd18));   // r17 from memory
        prog.push_back(r_inst(FN_AND, 5'd20, 5'd19, 5'd16));
        prog.push_back(r_inst(FN_NOR, 5'd21, 5'd18, 5'd15));
        prog.push_back(r_inst(FN_OR, 5'd22, 5'd21, 5'd21));
        // Execute must win over memory for the same register
        prog.push_back(i_inst(OP_ORI, 5'd23, 5'd0, 16'h1111));
        prog.push_back(i_inst(OP_ORI, 5'd23, 5'd0, 16'h2222));
        prog.push_back(r_inst(FN_OR, 5'd24, 5'd23, 5'd0));
        run_program("dependent_chain");
    endtask

    task automatic imm_zero_extend();
        prog.delete();
        prog.push_back(i_inst(OP_LUI, 5'd25, 5'd0, 16'hFFFF));
        prog.push_back(i_inst(OP_ORI, 5'd25, 5'd25, 16'hFFFF));
        prog.push_back(i_inst(OP_ANDI, 5'd26, 5'd25, 16'h8001));
        prog.push_back(i_inst(OP_XORI, 5'd27, 5'd25, 16'hF0F0));
        prog.push_back(i_inst(OP_ANDI, 5'd28, 5'd25, 16'($urandom()) | 16'h8000));
        prog.push_back(i_inst(OP_XORI, 5'd29, 5'd0, 16'($urandom()) | 16'h8000));
        run_program("imm_zero_extend");
    endtask

    task automatic invalid_skipped();
        prog.delete();
        prog.push_back(i_inst(OP_ORI, 5'd1, 5'd0, 16'($urandom())));
        prog.push_back(i_inst(6'h3F, 5'd1, 5'd0, 16'hFFFF));          // Unknown opcode
        prog.push_back(i_inst(OP_ORI, 5'd2, 5'd1, 16'($urandom())));
        prog.push_back(r_inst(6'h20, 5'd1, 5'd2, 5'd2));              // ADD is not supported
        prog.push_back(r_inst(FN_AND, 5'd2, 5'd1, 5'd1) | 32'h0000_00C0);  // Shift field set
        prog.push_back(r_inst(FN_OR, 5'd3, 5'd1, 5'd2));
        prog.push_back(i_inst(6'h08, 5'd3, 5'd0, 16'h7777));
        prog.push_back(32'h0000_0000);
        prog.push_back(r_inst(FN_XOR, 5'd4, 5'd3, 5'd1));
        prog.push_back(r_inst(FN_AND, 5'd5, 5'd4, 5'd2));
        run_program("invalid_skipped");
    endtask

    task automatic r0_writes();
        prog.delete();
        prog.push_back(i_inst(OP_ORI, 5'd0, 5'd0, 16'h1234));
        prog.push_back(r_inst(FN_OR, 5'd6, 5'd0, 5'd0));
        prog.push_back(i_inst(OP_ORI, 5'd7, 5'd0, 16'h00FF));
        prog.push_back(i_inst(OP_ORI, 5'd0, 5'd7, 16'hFF00));
        prog.push_back(r_inst(FN_OR, 5'd8, 5'd0, 5'd7));
        prog.push_back(r_inst(FN_XOR, 5'd9, 5'd7, 5'd0));
        prog.push_back(r_inst(FN_NOR, 5'd10, 5'd0, 5'd0));
        run_program("r0_writes");
    endtask

    initial begin
        clk     = 1'b0;
        reset_i = 1'b1;
        void'($urandom(20));
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        ori_fill();
        lui_ori_constants();
        dependent_chain();
        imm_zero_extend();
        invalid_skipped();
        r0_writes();
        $display("Summary: %0d tests, %0d failed, %0d writes checked, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
common/cpu_pkg.sv
logic/fetch.sv
decode/id.sv
logic/regfile.sv
logic/ex.sv
logic/mem_wb.sv
logic/openmips.sv
tb/openmips_assert.sv
tb/openmips_tb.sv
